// File: lmem_pkg.sv
package lmem_pkg;

	// Request kind, encoded so it maps straight onto the RAM rw line
	typedef enum logic {
		REQ_WRITE = 1'b0,
		REQ_READ  = 1'b1
	} req_kind_t;

	// Identifies which requester a grant or a read in flight belongs to
	typedef enum logic {
		PORT_HOST = 1'b0,
		PORT_CPU  = 1'b1
	} port_id_t;

endpackage

// File: lmem_req_skid.sv
`timescale 1ns/1ns

module lmem_req_skid #(
	parameter int addr_w = 9,
	parameter int data_w = 16
) (
	input  logic                sys_clk,
	input  logic                reset,
	input  logic                in_valid,
	output logic                in_ready,
	input  lmem_pkg::req_kind_t in_kind,
	input  logic [addr_w-1:0]   in_addr,
	input  logic [data_w-1:0]   in_wdata,
	output logic                out_valid,
	input  logic                out_ready,
	output lmem_pkg::req_kind_t out_kind,
	output logic [addr_w-1:0]   out_addr,
	output logic [data_w-1:0]   out_wdata
);

	logic                skid_valid; // Second entry holds a request
	lmem_pkg::req_kind_t skid_kind;
	logic [addr_w-1:0]   skid_addr;
	logic [data_w-1:0]   skid_wdata;
	logic                in_fire;
	logic                out_free; // Output entry can be refilled on this edge

	// Ready only looks at the skid entry, so the arbiter grant never reaches the requester
	assign in_ready = ~skid_valid;
	assign in_fire = in_valid & in_ready;
	assign out_free = ~out_valid | out_ready;

	always_ff @(posedge sys_clk) begin
		if (reset) begin
			out_valid <= 1'b0;
			skid_valid <= 1'b0;
		end else if (out_free) begin
			out_valid <= skid_valid | in_fire; // Skid entry is older, it goes first
			skid_valid <= 1'b0;
		end else if (in_fire) begin
			skid_valid <= 1'b1; // Output is stalled, park the new request
		end
	end

	always_ff @(posedge sys_clk) begin
		if (out_free) begin
			if (skid_valid) begin
				out_kind <= skid_kind;
				out_addr <= skid_addr;
				out_wdata <= skid_wdata;
			end else begin
				out_kind <= in_kind;
				out_addr <= in_addr;
				out_wdata <= in_wdata;
			end
		end
		if (~out_free & in_fire) begin
			skid_kind <= in_kind;
			skid_addr <= in_addr;
			skid_wdata <= in_wdata;
		end
	end

endmodule

// File: lmem_arbiter.sv
`timescale 1ns/1ns

module lmem_arbiter #(
	parameter int addr_w = 9,
	parameter int data_w = 16
) (
	input  logic                sys_clk,
	input  logic                reset,
	input  logic                host_valid,
	input  lmem_pkg::req_kind_t host_kind,
	input  logic [addr_w-1:0]   host_addr,
	input  logic                cpu_valid,
	input  lmem_pkg::req_kind_t cpu_kind,
	input  logic [addr_w-1:0]   cpu_addr,
	input  logic [data_w-1:0]   host_wdata,
	input  logic [data_w-1:0]   cpu_wdata,
	input  logic                host_rsp_empty,
	input  logic                cpu_rsp_empty,
	input  logic                z_oe,
	output logic                host_grant,
	output logic                cpu_grant,
	output logic                cen,
	output logic                rw,
	output logic [addr_w-1:0]   a,
	output logic [data_w-1:0]   z_in,
	output logic                host_load,
	output logic                cpu_load
);

	lmem_pkg::port_id_t  last_grant; // Winner of the most recent grant
	lmem_pkg::port_id_t  rd_tag; // Owner of the read the RAM answers next cycle
	logic                host_elig;
	logic                cpu_elig;
	logic                sel_cpu;
	lmem_pkg::req_kind_t sel_kind;

	// RAM read latency is a single cycle, so one tag register covers every read in flight
	assign host_load = z_oe & (rd_tag == lmem_pkg::PORT_HOST);
	assign cpu_load = z_oe & (rd_tag == lmem_pkg::PORT_CPU);

	// A load strobe marks the cycle a read is in flight; after it the response
	// buffer is full, so together they keep a port to one outstanding read
	assign host_elig = host_valid &
		((host_kind == lmem_pkg::REQ_WRITE) | (~host_load & host_rsp_empty));
	assign cpu_elig = cpu_valid &
		((cpu_kind == lmem_pkg::REQ_WRITE) | (~cpu_load & cpu_rsp_empty));

	// On a tie the port that lost last time wins
	assign host_grant = host_elig & (~cpu_elig | (last_grant == lmem_pkg::PORT_CPU));
	assign cpu_grant = cpu_elig & ~host_grant;

	assign sel_cpu = cpu_grant;
	assign sel_kind = sel_cpu ? cpu_kind : host_kind;

	assign cen = ~(host_grant | cpu_grant); // Active low, idle when nobody is granted
	assign rw = (sel_kind == lmem_pkg::REQ_READ);
	assign a = sel_cpu ? cpu_addr : host_addr;
	assign z_in = sel_cpu ? cpu_wdata : host_wdata;

	always_ff @(posedge sys_clk) begin
		if (reset) begin
			last_grant <= lmem_pkg::PORT_CPU; // Host wins the first tie
			rd_tag <= lmem_pkg::PORT_HOST;
		end else begin
			if (~cen) begin
				last_grant <= sel_cpu ? lmem_pkg::PORT_CPU : lmem_pkg::PORT_HOST;
			end
			if (~cen & rw) begin
				rd_tag <= sel_cpu ? lmem_pkg::PORT_CPU : lmem_pkg::PORT_HOST;
			end
		end
	end

endmodule

// File: lmem_ram.sv
`timescale 1ns/1ns

module lmem_ram #(
	parameter int addr_w = 9,
	parameter int data_w = 16
) (
	input  logic              sys_clk,
	input  logic              cen,
	input  logic              rw,
	input  logic [addr_w-1:0] a,
	input  logic [data_w-1:0] z_in,
	output logic [data_w-1:0] z_out,
	output logic              z_oe
);

	logic [data_w-1:0] mem [0:(1<<addr_w)-1] = '{default: '0};
	logic              z_oe_r = 1'b0; // Power-up value keeps the flag quiet before first access

	assign z_oe = z_oe_r;

	always_ff @(posedge sys_clk) begin
		z_oe_r <= ~cen & rw; // Read data is valid in the following cycle

		if (~cen) begin
			if (~rw) begin
				mem[a] <= z_in;
			end
			z_out <= mem[a]; // Old word, even on a write
		end
	end

endmodule

// File: lmem_rsp_buf.sv
`timescale 1ns/1ns

module lmem_rsp_buf #(
	parameter int data_w = 16
) (
	input  logic              sys_clk,
	input  logic              reset,
	input  logic              load,
	input  logic [data_w-1:0] z_out,
	input  logic              rsp_ready,
	output logic              empty,
	output logic              rsp_valid,
	output logic [data_w-1:0] rsp_data
);

	logic full;

	assign empty = ~full;
	assign rsp_valid = full;

	// The arbiter only loads an empty buffer, so load and accept never overlap
	always_ff @(posedge sys_clk) begin
		if (reset) begin
			full <= 1'b0;
		end else if (load) begin
			full <= 1'b1;
		end else if (rsp_ready) begin
			full <= 1'b0; // Requester took the word
		end
	end

	always_ff @(posedge sys_clk) begin
		if (load) begin
			rsp_data <= z_out;
		end
	end

endmodule

// File: lmem_top.sv
`timescale 1ns/1ns

module lmem_top #(
	parameter int addr_w = 9,
	parameter int data_w = 16
) (
	input  logic                sys_clk,
	input  logic                reset,

	input  logic                host_req_valid,
	output logic                host_req_ready,
	input  lmem_pkg::req_kind_t host_req_kind,
	input  logic [addr_w-1:0]   host_req_addr,
	input  logic [data_w-1:0]   host_req_wdata,
	output logic                host_rsp_valid,
	input  logic                host_rsp_ready,
	output logic [data_w-1:0]   host_rsp_data,

	input  logic                cpu_req_valid,
	output logic                cpu_req_ready,
	input  lmem_pkg::req_kind_t cpu_req_kind,
	input  logic [addr_w-1:0]   cpu_req_addr,
	input  logic [data_w-1:0]   cpu_req_wdata,
	output logic                cpu_rsp_valid,
	input  logic                cpu_rsp_ready,
	output logic [data_w-1:0]   cpu_rsp_data
);

	// Skid outputs toward the arbiter
	logic                host_valid;
	lmem_pkg::req_kind_t host_kind;
	logic [addr_w-1:0]   host_addr;
	logic [data_w-1:0]   host_wdata;
	logic                host_grant;
	logic                cpu_valid;
	lmem_pkg::req_kind_t cpu_kind;
	logic [addr_w-1:0]   cpu_addr;
	logic [data_w-1:0]   cpu_wdata;
	logic                cpu_grant;

	logic                cen;
	logic                rw;
	logic [addr_w-1:0]   a;
	logic [data_w-1:0]   z_in;
	logic [data_w-1:0]   z_out;
	logic                z_oe;

	logic                host_load;
	logic                cpu_load;
	logic                host_rsp_empty;
	logic                cpu_rsp_empty;

	lmem_req_skid #(.addr_w(addr_w), .data_w(data_w)) host_skid (
		.sys_clk(sys_clk), .reset(reset),
		.in_valid(host_req_valid), .in_ready(host_req_ready), .in_kind(host_req_kind),
		.in_addr(host_req_addr), .in_wdata(host_req_wdata),
		.out_valid(host_valid), .out_ready(host_grant), .out_kind(host_kind),
		.out_addr(host_addr), .out_wdata(host_wdata)
	);

	lmem_req_skid #(.addr_w(addr_w), .data_w(data_w)) cpu_skid (
		.sys_clk(sys_clk), .reset(reset),
		.in_valid(cpu_req_valid), .in_ready(cpu_req_ready), .in_kind(cpu_req_kind),
		.in_addr(cpu_req_addr), .in_wdata(cpu_req_wdata),
		.out_valid(cpu_valid), .out_ready(cpu_grant), .out_kind(cpu_kind),
		.out_addr(cpu_addr), .out_wdata(cpu_wdata)
	);

	lmem_arbiter #(.addr_w(addr_w), .data_w(data_w)) arb (
		.sys_clk(sys_clk), .reset(reset),
		.host_valid(host_valid), .host_kind(host_kind), .host_addr(host_addr),
		.cpu_valid(cpu_valid), .cpu_kind(cpu_kind), .cpu_addr(cpu_addr),
		.host_wdata(host_wdata), .cpu_wdata(cpu_wdata),
		.host_rsp_empty(host_rsp_empty), .cpu_rsp_empty(cpu_rsp_empty), .z_oe(z_oe),
		.host_grant(host_grant), .cpu_grant(cpu_grant),
		.cen(cen), .rw(rw), .a(a), .z_in(z_in),
		.host_load(host_load), .cpu_load(cpu_load)
	);

	lmem_ram #(.addr_w(addr_w), .data_w(data_w)) ram (
		.sys_clk(sys_clk), .cen(cen), .rw(rw), .a(a), .z_in(z_in),
		.z_out(z_out), .z_oe(z_oe)
	);

	// Both response buffers watch the same RAM output, the load strobe picks the owner
	lmem_rsp_buf #(.data_w(data_w)) host_rsp (
		.sys_clk(sys_clk), .reset(reset), .load(host_load), .z_out(z_out),
		.rsp_ready(host_rsp_ready), .empty(host_rsp_empty),
		.rsp_valid(host_rsp_valid), .rsp_data(host_rsp_data)
	);

	lmem_rsp_buf #(.data_w(data_w)) cpu_rsp (
		.sys_clk(sys_clk), .reset(reset), .load(cpu_load), .z_out(z_out),
		.rsp_ready(cpu_rsp_ready), .empty(cpu_rsp_empty),
		.rsp_valid(cpu_rsp_valid), .rsp_data(cpu_rsp_data)
	);

endmodule

// File: lmem_tb.sv
`timescale 1ns/1ns

module lmem_tb;

	localparam int addr_w = 9;
	localparam int data_w = 16;
	localparam int clk_period = 40;
	localparam int rand_n = 150; // Random requests per port
	localparam int bp_cycles = 40;
	localparam int fair_cycles = 200;
	localparam int half_words = 1 << (addr_w - 1);
	// Forty cycles for every request the tests issue, plus room for reset and draining
	localparam int timeout_cycles =
		(5 + 2 * (rand_n + bp_cycles + fair_cycles + half_words)) * 40 + 500;

	logic                sys_clk;
	logic                reset;
	logic                host_req_valid;
	logic                host_req_ready;
	lmem_pkg::req_kind_t host_req_kind;
	logic [addr_w-1:0]   host_req_addr;
	logic [data_w-1:0]   host_req_wdata;
	logic                host_rsp_valid;
	logic                host_rsp_ready;
	logic [data_w-1:0]   host_rsp_data;
	logic                cpu_req_valid;
	logic                cpu_req_ready;
	lmem_pkg::req_kind_t cpu_req_kind;
	logic [addr_w-1:0]   cpu_req_addr;
	logic [data_w-1:0]   cpu_req_wdata;
	logic                cpu_rsp_valid;
	logic                cpu_rsp_ready;
	logic [data_w-1:0]   cpu_rsp_data;

	logic [31:0]         lfsr = 32'h75ed;
	logic [data_w-1:0]   ref_mem [0:(1<<addr_w)-1] = '{default: '0};
	logic [data_w-1:0]   host_exp [$]; // Expected read data, oldest first
	logic [data_w-1:0]   cpu_exp [$];
	int                  cpu_rsp_count = 0;

	lmem_top #(.addr_w(addr_w), .data_w(data_w)) lmem_top_i (
		.sys_clk(sys_clk), .reset(reset),
		.host_req_valid(host_req_valid), .host_req_ready(host_req_ready),
		.host_req_kind(host_req_kind), .host_req_addr(host_req_addr),
		.host_req_wdata(host_req_wdata), .host_rsp_valid(host_rsp_valid),
		.host_rsp_ready(host_rsp_ready), .host_rsp_data(host_rsp_data),
		.cpu_req_valid(cpu_req_valid), .cpu_req_ready(cpu_req_ready),
		.cpu_req_kind(cpu_req_kind), .cpu_req_addr(cpu_req_addr),
		.cpu_req_wdata(cpu_req_wdata), .cpu_rsp_valid(cpu_rsp_valid),
		.cpu_rsp_ready(cpu_rsp_ready), .cpu_rsp_data(cpu_rsp_data)
	);

	// Galois form of x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], lfsr[0]}; // One step per bit
			lfsr = lfsr_step(lfsr);
		end
		return v;
	endfunction

	// Memory model: every request sees the stored word, and a write then replaces it
	function automatic logic [data_w-1:0] ref_access(input lmem_pkg::req_kind_t kind,
			input logic [addr_w-1:0] addr, input logic [data_w-1:0] wdata);
		logic [data_w-1:0] old;
		old = ref_mem[addr];
		if (kind == lmem_pkg::REQ_WRITE) begin
			ref_mem[addr] = wdata;
		end
		return old;
	endfunction

	task automatic abort(input string why);
		$display("%s", why);
		$display("Test failed");
		$fatal(1);
	endtask

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			abort($sformatf("** Error at %0t ns: %s = 0x%0h, expected 0x%0h",
				$time, name, got, exp));
		end
	endtask

	initial begin
		sys_clk = 1'b0;
		forever #(clk_period / 2) sys_clk = ~sys_clk;
	end

	initial begin
		#(timeout_cycles * clk_period);
		abort("Watchdog expired before all tests finished");
	end

	// Ports own separate halves, so each port's requests update the model in its own order
	always @(posedge sys_clk) begin : track_requests
		logic [data_w-1:0] word;
		if (!reset && host_req_valid && host_req_ready) begin
			word = ref_access(host_req_kind, host_req_addr, host_req_wdata);
			if (host_req_kind == lmem_pkg::REQ_READ) host_exp.push_back(word);
		end
		if (!reset && cpu_req_valid && cpu_req_ready) begin
			word = ref_access(cpu_req_kind, cpu_req_addr, cpu_req_wdata);
			if (cpu_req_kind == lmem_pkg::REQ_READ) cpu_exp.push_back(word);
		end
	end

	always @(posedge sys_clk) begin : compare_responses
		if (!reset && host_rsp_valid && host_rsp_ready) begin
			if (host_exp.size() == 0) begin
				abort("Host port returned a response with no read pending");
			end else begin
				check("host_rsp_data", 32'(host_rsp_data), 32'(host_exp.pop_front()));
			end
		end
		if (!reset && cpu_rsp_valid && cpu_rsp_ready) begin
			if (cpu_exp.size() == 0) begin
				abort("Processor port returned a response with no read pending");
			end else begin
				check("cpu_rsp_data", 32'(cpu_rsp_data), 32'(cpu_exp.pop_front()));
				cpu_rsp_count++;
			end
		end
	end

	// Drives one request and holds it until the port takes it
	task automatic issue(input lmem_pkg::port_id_t p, input lmem_pkg::req_kind_t kind,
			input logic [addr_w-1:0] addr, input logic [data_w-1:0] wdata);
		if (p == lmem_pkg::PORT_HOST) begin
			host_req_valid <= 1'b1;
			host_req_kind <= kind;
			host_req_addr <= addr;
			host_req_wdata <= wdata;
		end else begin
			cpu_req_valid <= 1'b1;
			cpu_req_kind <= kind;
			cpu_req_addr <= addr;
			cpu_req_wdata <= wdata;
		end
		do @(posedge sys_clk);
		while (p == lmem_pkg::PORT_HOST ? !host_req_ready : !cpu_req_ready);
		host_req_valid <= 1'b0; // Only one port is active during directed requests
		cpu_req_valid <= 1'b0;
	endtask

	// Drops each valid only on the edge its last request is taken
	task automatic release_ports();
		while (host_req_valid || cpu_req_valid) begin
			@(posedge sys_clk);
			if (host_req_ready) host_req_valid <= 1'b0;
			if (cpu_req_ready) cpu_req_valid <= 1'b0;
		end
	endtask

	task automatic wait_idle();
		do @(negedge sys_clk);
		while (host_exp.size() != 0 || cpu_exp.size() != 0);
		@(posedge sys_clk);
	endtask

	task automatic pick_req(input logic top, input int idx, input bit sweep,
			output lmem_pkg::req_kind_t kind, output logic [addr_w-1:0] addr,
			output logic [data_w-1:0] wdata);
		logic [31:0] r;
		if (sweep) begin
			kind = lmem_pkg::REQ_READ;
			addr = {top, idx[addr_w-2:0]};
			wdata = '0;
		end else begin
			kind = (take_bits(1) != 0) ? lmem_pkg::REQ_READ : lmem_pkg::REQ_WRITE;
			r = take_bits(addr_w - 1);
			addr = {top, r[addr_w-2:0]}; // Top address bit picks the port's own half
			r = take_bits(data_w);
			wdata = r[data_w-1:0];
		end
	endtask

	// Both ports at once, either random requests or a read of every word in their half
	task automatic run_traffic(input int n, input bit sweep);
		int host_sent;
		int cpu_sent;
		bit host_pend;
		bit cpu_pend;
		lmem_pkg::req_kind_t kind;
		logic [addr_w-1:0] addr;
		logic [data_w-1:0] wdata;
		host_sent = 0;
		cpu_sent = 0;
		host_pend = 1'b0;
		cpu_pend = 1'b0;
		while (host_sent < n || cpu_sent < n || host_pend || cpu_pend) begin
			@(posedge sys_clk);
			if (host_req_ready) host_pend = 1'b0; // A held request went through here
			if (cpu_req_ready) cpu_pend = 1'b0;
			if (!host_pend && host_sent < n && (sweep || take_bits(1) != 0)) begin
				pick_req(1'b1, host_sent, sweep, kind, addr, wdata);
				host_req_kind <= kind;
				host_req_addr <= addr;
				host_req_wdata <= wdata;
				host_pend = 1'b1;
				host_sent++;
			end
			if (!cpu_pend && cpu_sent < n && (sweep || take_bits(1) != 0)) begin
				pick_req(1'b0, cpu_sent, sweep, kind, addr, wdata);
				cpu_req_kind <= kind;
				cpu_req_addr <= addr;
				cpu_req_wdata <= wdata;
				cpu_pend = 1'b1;
				cpu_sent++;
			end
			host_req_valid <= host_pend;
			cpu_req_valid <= cpu_pend;
			if (!sweep) begin
				host_rsp_ready <= (take_bits(2) != 0);
				cpu_rsp_ready <= (take_bits(2) != 0);
			end
		end
	endtask

	task automatic hold_host_responses();
		bit seen;
		int cpu_start;
		seen = 1'b0;
		cpu_start = cpu_rsp_count;
		host_rsp_ready <= 1'b0;
		host_req_valid <= 1'b1;
		host_req_kind <= lmem_pkg::REQ_READ;
		host_req_addr <= 9'h1a0;
		cpu_req_valid <= 1'b1;
		cpu_req_kind <= lmem_pkg::REQ_READ;
		cpu_req_addr <= 9'h033;
		repeat (bp_cycles) begin
			@(negedge sys_clk);
			if (host_rsp_valid) begin
				seen = 1'b1;
			end
			// The stalled word is the oldest read the model expects on this port
			if (seen) begin
				check("host_rsp_valid", 32'(host_rsp_valid), 32'd1);
				check("host_rsp_data", 32'(host_rsp_data), 32'(host_exp[0]));
			end
		end
		if (!seen) abort("Host response never arrived while rsp_ready was held low");
		check("host_req_ready", 32'(host_req_ready), 32'd0);
		if (cpu_rsp_count - cpu_start < 5) begin
			abort("Processor port stopped completing reads while the host was stalled");
		end
		@(posedge sys_clk);
		host_rsp_ready <= 1'b1;
		release_ports();
		wait_idle();
	endtask

	task automatic check_fair_share();
		int host_n;
		int cpu_n;
		lmem_pkg::req_kind_t kind;
		logic [addr_w-1:0] addr;
		logic [data_w-1:0] wdata;
		host_n = 0;
		cpu_n = 0;
		host_req_kind <= lmem_pkg::REQ_WRITE; // Writes keep both ports eligible every cycle
		cpu_req_kind <= lmem_pkg::REQ_WRITE;
		repeat (fair_cycles) begin
			@(posedge sys_clk);
			if (host_req_valid && host_req_ready) host_n++;
			if (cpu_req_valid && cpu_req_ready) cpu_n++;
			if (!host_req_valid || host_req_ready) begin
				pick_req(1'b1, 0, 1'b0, kind, addr, wdata);
				host_req_valid <= 1'b1;
				host_req_addr <= addr;
				host_req_wdata <= wdata;
			end
			if (!cpu_req_valid || cpu_req_ready) begin
				pick_req(1'b0, 0, 1'b0, kind, addr, wdata);
				cpu_req_valid <= 1'b1;
				cpu_req_addr <= addr;
				cpu_req_wdata <= wdata;
			end
		end
		release_ports();
		wait_idle();
		if (host_n * 10 < (host_n + cpu_n) * 4 || cpu_n * 10 < (host_n + cpu_n) * 4) begin
			abort($sformatf("Unfair arbitration, host got %0d and processor %0d requests",
				host_n, cpu_n));
		end
	endtask

	initial begin
		reset <= 1'b1;
		host_req_valid <= 1'b0;
		host_req_kind <= lmem_pkg::REQ_WRITE;
		host_req_addr <= '0;
		host_req_wdata <= '0;
		host_rsp_ready <= 1'b1;
		cpu_req_valid <= 1'b0;
		cpu_req_kind <= lmem_pkg::REQ_WRITE;
		cpu_req_addr <= '0;
		cpu_req_wdata <= '0;
		cpu_rsp_ready <= 1'b1;
		repeat (2) @(posedge sys_clk);
		reset <= 1'b0;

		@(negedge sys_clk);
		check("host_req_ready", 32'(host_req_ready), 32'd1);
		check("cpu_req_ready", 32'(cpu_req_ready), 32'd1);
		check("host_rsp_valid", 32'(host_rsp_valid), 32'd0);
		check("cpu_rsp_valid", 32'(cpu_rsp_valid), 32'd0);
		@(posedge sys_clk);

		issue(lmem_pkg::PORT_HOST, lmem_pkg::REQ_WRITE, 9'h1a0, 16'h1234);
		issue(lmem_pkg::PORT_HOST, lmem_pkg::REQ_READ, 9'h1a0, '0);
		issue(lmem_pkg::PORT_HOST, lmem_pkg::REQ_READ, 9'h1ff, '0); // Never written
		issue(lmem_pkg::PORT_CPU, lmem_pkg::REQ_WRITE, 9'h033, 16'hbeef);
		issue(lmem_pkg::PORT_CPU, lmem_pkg::REQ_READ, 9'h033, '0);
		wait_idle();

		run_traffic(rand_n, 1'b0);
		host_rsp_ready <= 1'b1;
		cpu_rsp_ready <= 1'b1;
		wait_idle();

		hold_host_responses();
		check_fair_share();

		run_traffic(half_words, 1'b1);
		wait_idle();

		$display("Test completed successfully");
		$finish;
	end

endmodule

// File: compile.f
lmem_pkg.sv
lmem_req_skid.sv
lmem_arbiter.sv
lmem_ram.sv
lmem_rsp_buf.sv
lmem_top.sv
lmem_tb.sv

// File: run.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and looks for the pass line in the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f compile.f --top-module lmem_tb -o lmem_sim
./obj_dir/lmem_sim | tee sim.log

if grep -q "Test completed successfully" sim.log; then
	exit 0
fi
exit 1
